// File: clk_mon_pkg.sv
package clk_mon_pkg;

  // number of monitored clocks.
  localparam int NUM_CLK = 4;

  // reported count width; the measured-side counter is one bit wider.
  localparam int COUNT_WIDTH = 32;

  // window counter width in up_clk cycles.
  // kept short for simulation, 16 gives the full length window.
  localparam int MON_WINDOW_BITS = 10;

  // up bus widths.
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  // bits needed to index a channel inside an address block.
  localparam int CHAN_BITS = $clog2(NUM_CLK);

  // register map, one word per channel in each block.
  localparam logic [ADDR_WIDTH-1:0] ADDR_COUNT_BASE = 8'h10;
  localparam logic [ADDR_WIDTH-1:0] ADDR_MIN_BASE   = 8'h20;
  localparam logic [ADDR_WIDTH-1:0] ADDR_MAX_BASE   = 8'h30;

  // sticky alarm status, write 1 to clear.
  localparam logic [ADDR_WIDTH-1:0] ADDR_ALARM      = 8'h40;

  // interrupt enable per channel.
  localparam logic [ADDR_WIDTH-1:0] ADDR_ALARM_MASK = 8'h41;

  // counts and limits.
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // one bit per channel.
  typedef logic [NUM_CLK-1:0] chan_mask_t;

  // channel index within an address block.
  typedef logic [CHAN_BITS-1:0] chan_idx_t;

endpackage

// File: limit_cfg_if.sv
`timescale 1ns/100ps

interface limit_cfg_if import clk_mon_pkg::*; ();

  // measured counts and their update strobes.
  count_t     count [NUM_CLK];
  chan_mask_t count_valid;

  // software limits and interrupt mask.
  count_t     min_limit [NUM_CLK];
  count_t     max_limit [NUM_CLK];
  chan_mask_t alarm_mask;

  // one-cycle clear pulses and the sticky alarm state.
  chan_mask_t alarm_clr;
  chan_mask_t alarm;

  modport regs (
    input  count, count_valid, alarm,
    output min_limit, max_limit, alarm_mask, alarm_clr
  );

  modport chk (
    input  count, count_valid, min_limit, max_limit, alarm_mask, alarm_clr,
    output alarm
  );

  modport source (
    output count, count_valid
  );

endinterface

// File: clk_count_mon.sv
`timescale 1ns/100ps

module clk_count_mon import clk_mon_pkg::*; (
  input  logic   up_clk,
  input  logic   d_rst,
  input  logic   meas_clk,
  output count_t count,
  output logic   count_valid
);

  logic [MON_WINDOW_BITS-1:0] up_window;
  logic                       up_run;
  logic                       up_running_m1;
  logic                       up_running_m2;
  logic                       up_running_m3;
  logic                       up_capture;
  logic                       up_stopped;

  logic                       meas_run_m1;
  logic                       meas_run_m2;
  logic                       meas_run_m3;
  logic                       meas_start;
  logic [COUNT_WIDTH:0]       meas_count;

  // returned run level falls, the measured counter is frozen.
  assign up_capture = up_running_m3 & ~up_running_m2;

  // window wrapped while the measured side never followed the run level.
  assign up_stopped = (up_window == '0) && (up_run != up_running_m3);

  // run level coming back from the measured domain.
  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      up_running_m1 <= 1'b0;
      up_running_m2 <= 1'b0;
      up_running_m3 <= 1'b0;
    end else begin
      up_running_m1 <= meas_run_m3;
      up_running_m2 <= up_running_m1;
      up_running_m3 <= up_running_m2;
    end
  end

  // window counter, idles at one between measurements.
  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      up_window <= MON_WINDOW_BITS'(1);
    end else if (!up_run && !up_running_m3) begin
      up_window <= MON_WINDOW_BITS'(1);
    end else begin
      up_window <= up_window + 1'b1;
    end
  end

  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      up_run      <= 1'b0;
      count       <= '0;
      count_valid <= 1'b0;
    end else begin
      if (!up_running_m3) begin
        up_run <= 1'b1;
      end else if (up_window == '0) begin
        up_run <= 1'b0;
      end
      count_valid <= up_capture | up_stopped;
      if (up_capture) begin
        // a saturated counter reports all ones.
        count <= meas_count[COUNT_WIDTH] ? '1 : meas_count[COUNT_WIDTH-1:0];
      end else if (up_stopped) begin
        count <= '0;
      end
    end
  end

  // run level into the measured domain.
  always_ff @(posedge meas_clk or posedge d_rst) begin
    if (d_rst) begin
      meas_run_m1 <= 1'b0;
      meas_run_m2 <= 1'b0;
      meas_run_m3 <= 1'b0;
    end else begin
      meas_run_m1 <= up_run;
      meas_run_m2 <= meas_run_m1;
      meas_run_m3 <= meas_run_m2;
    end
  end

  // counter restarts as the run level rises.
  assign meas_start = meas_run_m2 & ~meas_run_m3;

  always_ff @(posedge meas_clk) begin
    if (meas_start) begin
      meas_count <= '0;
    end else if (meas_run_m3) begin
      if (!meas_count[COUNT_WIDTH]) begin
        meas_count <= meas_count + 1'b1;
      end else begin
        meas_count <= '1;
      end
    end
  end

  // one result per measurement.
  assert property (@(posedge up_clk) disable iff (d_rst)
    count_valid |=> !count_valid)
    else $error("count_valid held for two cycles");

endmodule

// File: clk_limit_check.sv
`timescale 1ns/100ps

module clk_limit_check import clk_mon_pkg::*; (
  input  logic        up_clk,
  input  logic        d_rst,
  limit_cfg_if.chk    cfg,
  output logic        alarm_irq
);

  chan_mask_t alarm_set;
  chan_mask_t alarm_q;

  // a fresh count outside its window.
  always_comb begin
    alarm_set = '0;
    for (int i = 0; i < NUM_CLK; i++) begin
      if (cfg.count_valid[i]) begin
        alarm_set[i] = (cfg.count[i] < cfg.min_limit[i]) ||
                       (cfg.count[i] > cfg.max_limit[i]);
      end
    end
  end

  // sticky bits, a new violation wins over a clear.
  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      alarm_q <= '0;
    end else begin
      alarm_q <= (alarm_q & ~cfg.alarm_clr) | alarm_set;
    end
  end

  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      alarm_irq <= 1'b0;
    end else begin
      alarm_irq <= |(alarm_q & cfg.alarm_mask);
    end
  end

  assign cfg.alarm = alarm_q;

  // an alarm only drops after software asked for it.
  for (genvar i = 0; i < NUM_CLK; i++) begin : g_alarm_chk
    assert property (@(posedge up_clk) disable iff (d_rst)
      $fell(alarm_q[i]) |-> $past(cfg.alarm_clr[i]))
      else $error("alarm bit %0d fell without a clear", i);
  end

endmodule

// File: clk_mon_regs.sv
`timescale 1ns/100ps

module clk_mon_regs import clk_mon_pkg::*; (
  input  logic                  up_clk,
  input  logic                  d_rst,
  input  logic                  up_wreq,
  input  logic [ADDR_WIDTH-1:0] up_waddr,
  input  logic [DATA_WIDTH-1:0] up_wdata,
  output logic                  up_wack,
  input  logic                  up_rreq,
  input  logic [ADDR_WIDTH-1:0] up_raddr,
  output logic [DATA_WIDTH-1:0] up_rdata,
  output logic                  up_rack,
  limit_cfg_if.regs             cfg
);

  count_t                min_q [NUM_CLK];
  count_t                max_q [NUM_CLK];
  chan_mask_t            mask_q;
  chan_mask_t            clr_q;
  chan_idx_t             widx;
  chan_idx_t             ridx;
  logic [DATA_WIDTH-1:0] rd_mux;

  // true when addr falls in the per-channel block starting at base.
  function automatic logic in_block(input logic [ADDR_WIDTH-1:0] addr,
                                    input logic [ADDR_WIDTH-1:0] base);
    return addr[ADDR_WIDTH-1:CHAN_BITS] == base[ADDR_WIDTH-1:CHAN_BITS];
  endfunction

  assign widx = up_waddr[CHAN_BITS-1:0];
  assign ridx = up_raddr[CHAN_BITS-1:0];

  // writes land on the same edge that raises the ack.
  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      up_wack <= 1'b0;
      mask_q  <= '0;
      clr_q   <= '0;
      for (int i = 0; i < NUM_CLK; i++) begin
        min_q[i] <= '0;
        max_q[i] <= '1;
      end
    end else begin
      up_wack <= up_wreq;
      clr_q   <= '0;
      if (up_wreq) begin
        if (in_block(up_waddr, ADDR_MIN_BASE)) begin
          min_q[widx] <= up_wdata;
        end else if (in_block(up_waddr, ADDR_MAX_BASE)) begin
          max_q[widx] <= up_wdata;
        end else if (up_waddr == ADDR_ALARM) begin
          clr_q <= up_wdata[NUM_CLK-1:0];
        end else if (up_waddr == ADDR_ALARM_MASK) begin
          mask_q <= up_wdata[NUM_CLK-1:0];
        end
      end
    end
  end

  // unmapped addresses fall through to zero.
  always_comb begin
    rd_mux = '0;
    if (in_block(up_raddr, ADDR_COUNT_BASE)) begin
      rd_mux = cfg.count[ridx];
    end else if (in_block(up_raddr, ADDR_MIN_BASE)) begin
      rd_mux = min_q[ridx];
    end else if (in_block(up_raddr, ADDR_MAX_BASE)) begin
      rd_mux = max_q[ridx];
    end else if (up_raddr == ADDR_ALARM) begin
      rd_mux = DATA_WIDTH'(cfg.alarm);
    end else if (up_raddr == ADDR_ALARM_MASK) begin
      rd_mux = DATA_WIDTH'(mask_q);
    end
  end

  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      up_rack <= 1'b0;
    end else begin
      up_rack <= up_rreq;
    end
  end

  always_ff @(posedge up_clk) begin
    if (up_rreq) begin
      up_rdata <= rd_mux;
    end
  end

  assign cfg.min_limit  = min_q;
  assign cfg.max_limit  = max_q;
  assign cfg.alarm_mask = mask_q;
  assign cfg.alarm_clr  = clr_q;

  // every write is answered on the next cycle.
  assert property (@(posedge up_clk) disable iff (d_rst)
    up_wreq |=> up_wack)
    else $error("write request without ack");

endmodule

// File: clk_mon_top.sv
`timescale 1ns/100ps

module clk_mon_top import clk_mon_pkg::*; (
  input  logic                  up_clk,
  input  logic                  d_rst,
  input  logic [NUM_CLK-1:0]    meas_clk,
  input  logic                  up_wreq,
  input  logic [ADDR_WIDTH-1:0] up_waddr,
  input  logic [DATA_WIDTH-1:0] up_wdata,
  output logic                  up_wack,
  input  logic                  up_rreq,
  input  logic [ADDR_WIDTH-1:0] up_raddr,
  output logic [DATA_WIDTH-1:0] up_rdata,
  output logic                  up_rack,
  output logic                  alarm_irq
);

  count_t     mon_count [NUM_CLK];
  chan_mask_t mon_valid;

  limit_cfg_if u_cfg ();

  // one monitor per measured clock.
  for (genvar i = 0; i < NUM_CLK; i++) begin : g_mon
    clk_count_mon u_clk_count_mon (
      .up_clk      (up_clk),
      .d_rst       (d_rst),
      .meas_clk    (meas_clk[i]),
      .count       (mon_count[i]),
      .count_valid (mon_valid[i])
    );
  end

  assign u_cfg.count       = mon_count;
  assign u_cfg.count_valid = mon_valid;

  clk_limit_check u_clk_limit_check (
    .up_clk    (up_clk),
    .d_rst     (d_rst),
    .cfg       (u_cfg.chk),
    .alarm_irq (alarm_irq)
  );

  clk_mon_regs u_clk_mon_regs (
    .up_clk   (up_clk),
    .d_rst    (d_rst),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack),
    .cfg      (u_cfg.regs)
  );

endmodule

// File: tb_clk_mon.sv
`timescale 1ns/100ps

module tb_clk_mon import clk_mon_pkg::*; ();

  localparam int UP_PERIOD    = 8;
  localparam int MEAS0_PERIOD = 4;
  localparam int MEAS1_PERIOD = 10;
  localparam int MEAS2_PERIOD = 16;
  localparam int COUNT_TOL    = 6;
  // a result takes a little over one window.
  localparam int RESULT_LIMIT = 2 * (2 ** MON_WINDOW_BITS);
  // about four times the length of all tests together.
  localparam int TIMEOUT_CYCLES = 40000;

  logic                  up_clk;
  logic                  d_rst;
  logic                  clk0;
  logic                  clk1;
  logic                  clk2;
  logic                  up_wreq;
  logic [ADDR_WIDTH-1:0] up_waddr;
  logic [DATA_WIDTH-1:0] up_wdata;
  logic                  up_wack;
  logic                  up_rreq;
  logic [ADDR_WIDTH-1:0] up_raddr;
  logic [DATA_WIDTH-1:0] up_rdata;
  logic                  up_rack;
  logic                  alarm_irq;
  int                    error_count;
  int                    test_count;
  int                    failed_count;
  int                    cycle_count;

  clk_mon_top u_clk_mon_top (
    .up_clk    (up_clk),
    .d_rst     (d_rst),
    .meas_clk  ({1'b0, clk2, clk1, clk0}),
    .up_wreq   (up_wreq),
    .up_waddr  (up_waddr),
    .up_wdata  (up_wdata),
    .up_wack   (up_wack),
    .up_rreq   (up_rreq),
    .up_raddr  (up_raddr),
    .up_rdata  (up_rdata),
    .up_rack   (up_rack),
    .alarm_irq (alarm_irq)
  );

  initial begin
    up_clk = 1'b0;
    forever #(UP_PERIOD / 2.0) up_clk = ~up_clk;
  end

  // measured clocks start off the up_clk edges.
  initial begin
    clk0 = 1'b0;
    #1.3;
    forever #(MEAS0_PERIOD / 2.0) clk0 = ~clk0;
  end

  initial begin
    clk1 = 1'b0;
    #2.1;
    forever #(MEAS1_PERIOD / 2.0) clk1 = ~clk1;
  end

  initial begin
    clk2 = 1'b0;
    #0.7;
    forever #(MEAS2_PERIOD / 2.0) clk2 = ~clk2;
  end

  function automatic logic [ADDR_WIDTH-1:0] chan_addr(input logic [ADDR_WIDTH-1:0] base,
                                                      input int ch);
    return base + ADDR_WIDTH'(ch);
  endfunction

  // window length in up_clk time divided by the measured period.
  function automatic count_t expected_count(input int period);
    return count_t'(((2 ** MON_WINDOW_BITS) * UP_PERIOD) / period);
  endfunction

  task automatic check_count(input string name, input count_t got, input count_t exp,
                             input int tol);
    longint diff;
    diff = longint'(got) - longint'(exp);
    if (diff < 0) begin
      diff = -diff;
    end
    if ($isunknown(got) || diff > tol) begin
      $display("Error: %s = 0x%08h, expected 0x%08h within %0d", name, got, exp, tol);
      error_count++;
    end
  endtask

  task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic up_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    int waited;
    @(posedge up_clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    @(posedge up_clk);
    up_wreq <= 1'b0;
    waited = 0;
    @(negedge up_clk);
    while (!up_wack && waited < 4) begin
      @(negedge up_clk);
      waited++;
    end
    if (!up_wack) begin
      $display("write to address 0x%02h was never acknowledged", addr);
      error_count++;
    end else if (waited != 0) begin
      $display("write ack for address 0x%02h came %0d cycles late", addr, waited);
      error_count++;
    end
  endtask

  task automatic up_read(input logic [ADDR_WIDTH-1:0] addr,
                         output logic [DATA_WIDTH-1:0] data);
    int waited;
    @(posedge up_clk);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge up_clk);
    up_rreq <= 1'b0;
    waited = 0;
    @(negedge up_clk);
    while (!up_rack && waited < 4) begin
      @(negedge up_clk);
      waited++;
    end
    data = up_rdata;
    if (!up_rack) begin
      $display("read of address 0x%02h was never acknowledged", addr);
      error_count++;
    end else if (waited != 0) begin
      $display("read ack for address 0x%02h came %0d cycles late", addr, waited);
      error_count++;
    end
  endtask

  task automatic read_count(input int ch, input count_t exp, input int tol);
    logic [DATA_WIDTH-1:0] rd;
    up_read(chan_addr(ADDR_COUNT_BASE, ch), rd);
    check_count($sformatf("count[%0d]", ch), rd, exp, tol);
  endtask

  task automatic read_alarm(input chan_mask_t exp);
    logic [DATA_WIDTH-1:0] rd;
    up_read(ADDR_ALARM, rd);
    check_mask("alarm", rd[NUM_CLK-1:0], exp);
  endtask

  // counts count_valid pulses until every listed channel has n of them.
  task automatic wait_results(input chan_mask_t chans, input int n);
    int  seen [NUM_CLK];
    int  cycles;
    logic done;
    foreach (seen[i]) begin
      seen[i] = 0;
    end
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < n * RESULT_LIMIT) begin
      @(negedge up_clk);
      cycles++;
      done = 1'b1;
      for (int i = 0; i < NUM_CLK; i++) begin
        if (u_clk_mon_top.mon_valid[i]) begin
          seen[i]++;
        end
        if (chans[i] && seen[i] < n) begin
          done = 1'b0;
        end
      end
    end
    if (!done) begin
      $display("channels 0x%h gave no fresh count within %0d cycles", chans, cycles);
      error_count++;
    end
  endtask

  task automatic wait_irq(input logic exp);
    int waited;
    waited = 0;
    @(negedge up_clk);
    while (alarm_irq !== exp && waited < 4) begin
      @(negedge up_clk);
      waited++;
    end
    check_level("alarm_irq", alarm_irq, exp);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_count, name,
               error_count - errs_before);
      failed_count++;
    end
  endtask

  task automatic test_reset();
    int                    errs;
    logic [DATA_WIDTH-1:0] rd;
    errs = error_count;
    for (int ch = 0; ch < NUM_CLK; ch++) begin
      read_count(ch, '0, 0);
    end
    read_alarm('0);
    up_read(ADDR_ALARM_MASK, rd);
    check_mask("alarm_mask", rd[NUM_CLK-1:0], '0);
    check_level("alarm_irq", alarm_irq, 1'b0);
    end_test("reset values", errs);
  endtask

  task automatic test_counts();
    int errs;
    errs = error_count;
    wait_results(4'b0111, 3);
    read_count(0, expected_count(MEAS0_PERIOD), COUNT_TOL);
    read_count(1, expected_count(MEAS1_PERIOD), COUNT_TOL);
    read_count(2, expected_count(MEAS2_PERIOD), COUNT_TOL);
    end_test("running clock counts", errs);
  endtask

  task automatic test_stopped();
    int errs;
    errs = error_count;
    read_count(3, '0, 0);
    up_write(chan_addr(ADDR_MIN_BASE, 3), 32'd1);
    wait_results(4'b1000, 1);
    read_alarm(4'b1000);
    up_write(ADDR_ALARM, 32'h8);
    read_alarm(4'b0000);
    wait_results(4'b1000, 1);
    read_alarm(4'b1000);
    // put channel 3 back to its open window.
    up_write(chan_addr(ADDR_MIN_BASE, 3), 32'd0);
    up_write(ADDR_ALARM, 32'h8);
    read_alarm(4'b0000);
    end_test("stopped clock alarm", errs);
  endtask

  task automatic test_limits();
    int     errs;
    count_t exp1;
    errs = error_count;
    exp1 = expected_count(MEAS1_PERIOD);
    up_write(chan_addr(ADDR_MIN_BASE, 1), exp1 - count_t'(16));
    up_write(chan_addr(ADDR_MAX_BASE, 1), exp1 + count_t'(16));
    up_write(ADDR_ALARM, 32'hf);
    wait_results(4'b0010, 2);
    read_alarm(4'b0000);
    up_write(chan_addr(ADDR_MAX_BASE, 1), exp1 - count_t'(16));
    wait_results(4'b0010, 1);
    read_alarm(4'b0010);
    end_test("min/max window", errs);
  endtask

  task automatic test_irq();
    int errs;
    errs = error_count;
    repeat (3) @(negedge up_clk);
    check_level("alarm_irq", alarm_irq, 1'b0);
    up_write(ADDR_ALARM_MASK, 32'h2);
    wait_irq(1'b1);
    up_write(chan_addr(ADDR_MAX_BASE, 1), '1);
    up_write(ADDR_ALARM, 32'hf);
    wait_irq(1'b0);
    read_alarm(4'b0000);
    wait_results(4'b0010, 1);
    read_alarm(4'b0000);
    check_level("alarm_irq", alarm_irq, 1'b0);
    up_write(ADDR_ALARM_MASK, 32'h0);
    end_test("masked interrupt", errs);
  endtask

  task automatic test_regs();
    int                    errs;
    logic [DATA_WIDTH-1:0] rd;
    errs = error_count;
    up_write(chan_addr(ADDR_MIN_BASE, 2), 32'h0000_0123);
    up_write(chan_addr(ADDR_MAX_BASE, 0), 32'hcafe_0042);
    up_read(chan_addr(ADDR_MIN_BASE, 2), rd);
    check_count("min_limit[2]", rd, 32'h0000_0123, 0);
    up_read(chan_addr(ADDR_MAX_BASE, 0), rd);
    check_count("max_limit[0]", rd, 32'hcafe_0042, 0);
    up_read(chan_addr(ADDR_MAX_BASE, 3), rd);
    check_count("max_limit[3]", rd, '1, 0);
    up_read(8'h7c, rd);
    check_count("unmapped 0x7c", rd, '0, 0);
    up_read(8'h42, rd);
    check_count("unmapped 0x42", rd, '0, 0);
    end_test("register readback", errs);
  endtask

  initial begin
    d_rst        = 1'b1;
    up_wreq      = 1'b0;
    up_waddr     = '0;
    up_wdata     = '0;
    up_rreq      = 1'b0;
    up_raddr     = '0;
    error_count  = 0;
    test_count   = 0;
    failed_count = 0;
    repeat (10) @(posedge up_clk);
    d_rst <= 1'b0;
    test_reset();
    test_counts();
    test_stopped();
    test_limits();
    test_irq();
    test_regs();
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             test_count, failed_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge up_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d up_clk cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: vlog.f
clk_mon_pkg.sv
limit_cfg_if.sv
clk_count_mon.sv
clk_limit_check.sv
clk_mon_regs.sv
clk_mon_top.sv
tb_clk_mon.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_clk_mon
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
